/* memtest_config.svh */
// widths, memory depth and latency for the memory self-test block
// host register offsets and LFSR pattern constants
`ifndef MEMTEST_CONFIG_SVH
`define MEMTEST_CONFIG_SVH

`define MEM_AW      8               // 256 words
`define DATA_W      32
`define REG_AW      8
`define RD_LAT      2               // test ram read latency in cycles
`define HB_W        24              // heartbeat counter

`define LFSR_SEED   32'hACE1_2468
`define LFSR_TAPS   32'h8020_0003   // galois form, x^32+x^22+x^2+x+1

// host register map
`define R_CTRL      8'h00
`define R_START     8'h04
`define R_STOP      8'h08
`define R_STATUS    8'h0C
`define R_ITER      8'h10
`define R_ERRS      8'h14
`define R_ERRADDR   8'h18
`define R_MADDR     8'h1C
`define R_MWDATA    8'h20
`define R_MREAD     8'h24
`define R_MRDATA    8'h28
`define R_LEDS      8'h2C

`endif

/* memtest_pkg.sv */
// shared types for the memory self-test block
// data, address, count and LED vectors, test engine states
`include "memtest_config.svh"

package memtest_pkg;

    typedef logic [`DATA_W-1:0] word_t;     // one memory or register word
    typedef logic [`MEM_AW-1:0] maddr_t;    // memory word address
    typedef logic [`REG_AW-1:0] raddr_t;    // host register offset
    typedef logic [15:0]        count_t;    // pass and error counts
    typedef logic [7:0]         led_t;

    // test engine sequence
    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        READ,
        DONE
    } tst_state_e;

endpackage

/* mem_port_if.sv */
// single word-wide memory port with requester and memory sides
`timescale 1ns/1ps

interface mem_port_if;

    logic                wr;        // one-cycle write strobe
    logic                rd;        // one-cycle read strobe
    memtest_pkg::maddr_t addr;
    memtest_pkg::word_t  wdata;
    logic                rvalid;
    memtest_pkg::word_t  rdata;
    logic                gnt;       // request taken this cycle

    modport requester (
        output wr,
        output rd,
        output addr,
        output wdata,
        input  rvalid,
        input  rdata,
        input  gnt
    );

    modport memory (
        input  wr,
        input  rd,
        input  addr,
        input  wdata,
        output rvalid,
        output rdata,
        output gnt
    );

endinterface

/* test_ram.sv */
// word memory with a fixed pipelined read latency
`timescale 1ns/1ps
`include "memtest_config.svh"

module test_ram (
    input  logic       mainclk_buf,
    input  logic       rst_n_i,
    mem_port_if.memory mem
);

    memtest_pkg::word_t  ram_q [0:(1 << `MEM_AW)-1];
    memtest_pkg::word_t  dat_q [`RD_LAT];       // read data pipeline
    logic [`RD_LAT-1:0]  vld_q;

    always_ff @(posedge mainclk_buf) begin
        if (mem.wr)
            ram_q[mem.addr] <= mem.wdata;
        if (mem.rd)
            dat_q[0] <= ram_q[mem.addr];
        for (int i = 1; i < `RD_LAT; i++)
            dat_q[i] <= dat_q[i-1];
    end

    always_ff @(posedge mainclk_buf or negedge rst_n_i) begin
        if (!rst_n_i)
            vld_q <= '0;
        else
            vld_q <= {vld_q[`RD_LAT-2:0], mem.rd};
    end

    assign mem.rvalid = vld_q[`RD_LAT-1];
    assign mem.rdata  = dat_q[`RD_LAT-1];
    assign mem.gnt    = 1'b1;       // always accepts

    a_no_rd_wr: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        !(mem.rd && mem.wr));

endmodule

/* mem_arbiter.sv */
// fixed-priority arbiter, manual port over test engine
// owner tags steer read returns back to the issuing port
`timescale 1ns/1ps
`include "memtest_config.svh"

module mem_arbiter (
    input  logic       mainclk_buf,
    input  logic       rst_n_i,
    mem_port_if.memory    man,
    mem_port_if.memory    tst,
    mem_port_if.requester ram
);

    logic              man_req;
    logic              tst_req;
    logic              tst_win;
    logic [`RD_LAT-1:0] own_q;      // 1 when the tester owns that read stage

    assign man_req = man.rd || man.wr;
    assign tst_req = tst.rd || tst.wr;
    assign tst_win = tst_req && !man_req && ram.gnt;

    assign ram.wr    = man_req ? man.wr : (tst_win && tst.wr);
    assign ram.rd    = man_req ? man.rd : (tst_win && tst.rd);
    assign ram.addr  = man_req ? man.addr : tst.addr;
    assign ram.wdata = man_req ? man.wdata : tst.wdata;

    assign man.gnt = ram.gnt;
    assign tst.gnt = tst_win;       // tester holds its request until this

    always_ff @(posedge mainclk_buf or negedge rst_n_i) begin
        if (!rst_n_i)
            own_q <= '0;
        else
            own_q <= {own_q[`RD_LAT-2:0], tst_win && tst.rd};
    end

    assign man.rvalid = ram.rvalid && !own_q[`RD_LAT-1];
    assign tst.rvalid = ram.rvalid && own_q[`RD_LAT-1];
    assign man.rdata  = ram.rdata;
    assign tst.rdata  = ram.rdata;

    // a read tagged for the tester always meets a ram return
    a_tag_aligned: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        own_q[`RD_LAT-1] |-> ram.rvalid);

endmodule

/* mem_tester.sv */
// memory test engine, write then compare over an address range
// address or LFSR data pattern, pass and error counters
`timescale 1ns/1ps
`include "memtest_config.svh"

module mem_tester (
    input  logic                mainclk_buf,
    input  logic                rst_n_i,
    input  logic                start_i,
    input  logic                check_only_i,
    input  logic                lfsr_mode_i,
    input  logic                clear_i,
    input  memtest_pkg::maddr_t addr_start_i,
    input  memtest_pkg::maddr_t addr_stop_i,
    output logic                busy_o,
    output logic                pass_o,
    output logic                fail_o,
    output memtest_pkg::count_t iterations_o,
    output memtest_pkg::count_t errors_o,
    output memtest_pkg::maddr_t err_addr_o,
    mem_port_if.requester       mem
);

    memtest_pkg::tst_state_e state_q;
    memtest_pkg::maddr_t     addr_q;        // next address to issue
    memtest_pkg::maddr_t     chk_addr_q;    // address of the next read return
    memtest_pkg::word_t      lfsr_q;
    memtest_pkg::word_t      pat;
    logic                    rd_all_q;      // every read of the pass issued
    logic                    mismatch;
    memtest_pkg::count_t     iter_q;
    memtest_pkg::count_t     err_q;
    memtest_pkg::maddr_t     err_addr_q;
    logic                    pass_q;
    logic                    fail_q;

    function automatic memtest_pkg::word_t lfsr_step(input memtest_pkg::word_t v);
        return v[0] ? ((v >> 1) ^ `LFSR_TAPS) : (v >> 1);
    endfunction

    // write data while writing, expected data while reading
    always_comb begin
        if (lfsr_mode_i)
            pat = lfsr_q;
        else if (state_q == memtest_pkg::WRITE)
            pat = memtest_pkg::word_t'(addr_q);
        else
            pat = memtest_pkg::word_t'(chk_addr_q);
    end

    assign mismatch = (state_q == memtest_pkg::READ) && mem.rvalid && (mem.rdata != pat);

    always_ff @(posedge mainclk_buf or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= memtest_pkg::IDLE;
            addr_q     <= '0;
            chk_addr_q <= '0;
            lfsr_q     <= '0;
            rd_all_q   <= 1'b0;
        end else begin
            case (state_q)
                memtest_pkg::IDLE: begin
                    if (start_i) begin
                        state_q    <= check_only_i ? memtest_pkg::READ : memtest_pkg::WRITE;
                        addr_q     <= addr_start_i;
                        chk_addr_q <= addr_start_i;
                        lfsr_q     <= `LFSR_SEED;
                        rd_all_q   <= 1'b0;
                    end
                end
                memtest_pkg::WRITE: begin
                    if (mem.gnt) begin
                        lfsr_q <= lfsr_step(lfsr_q);
                        if (addr_q == addr_stop_i) begin
                            state_q <= memtest_pkg::READ;
                            addr_q  <= addr_start_i;
                            lfsr_q  <= `LFSR_SEED;      // sequence restarts for compare
                        end else begin
                            addr_q  <= addr_q + 1'b1;
                        end
                    end
                end
                memtest_pkg::READ: begin
                    if (mem.gnt) begin
                        if (addr_q == addr_stop_i)
                            rd_all_q <= 1'b1;
                        else
                            addr_q <= addr_q + 1'b1;
                    end
                    // expected pattern steps with each return
                    if (mem.rvalid) begin
                        lfsr_q     <= lfsr_step(lfsr_q);
                        chk_addr_q <= chk_addr_q + 1'b1;
                        if (chk_addr_q == addr_stop_i)
                            state_q <= memtest_pkg::DONE;
                    end
                end
                default: state_q <= memtest_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge mainclk_buf or negedge rst_n_i) begin
        if (!rst_n_i) begin
            iter_q     <= '0;
            err_q      <= '0;
            err_addr_q <= '0;
            pass_q     <= 1'b0;
            fail_q     <= 1'b0;
        end else if (clear_i) begin
            iter_q <= '0;
            err_q  <= '0;
            pass_q <= 1'b0;
            fail_q <= 1'b0;
        end else begin
            if (mismatch) begin
                fail_q <= 1'b1;
                if (err_q != '1)
                    err_q <= err_q + 1'b1;      // saturates
                if (err_q == '0)
                    err_addr_q <= chk_addr_q;   // first failure since clear
            end
            if (state_q == memtest_pkg::DONE) begin
                iter_q <= iter_q + 1'b1;
                pass_q <= (err_q == '0);
            end
        end
    end

    assign mem.wr    = (state_q == memtest_pkg::WRITE);
    assign mem.rd    = (state_q == memtest_pkg::READ) && !rd_all_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = pat;

    assign busy_o       = (state_q != memtest_pkg::IDLE);
    assign pass_o       = pass_q;
    assign fail_o       = fail_q;
    assign iterations_o = iter_q;
    assign errors_o     = err_q;
    assign err_addr_o   = err_addr_q;

    a_addr_in_range: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        busy_o |-> (addr_q >= addr_start_i) && (addr_q <= addr_stop_i));

endmodule

/* ctrl_regs.sv */
// host register file with manual memory access sequencing
// status capture for the test engine and LED drive
`timescale 1ns/1ps
`include "memtest_config.svh"

module ctrl_regs (
    input  logic                mainclk_buf,
    input  logic                rst_n_i,
    input  memtest_pkg::raddr_t reg_addr_i,
    input  memtest_pkg::word_t  reg_wdata_i,
    input  logic                reg_write_i,
    input  logic                reg_read_i,
    output memtest_pkg::word_t  reg_rdata_o,
    output logic                reg_rvalid_o,
    output memtest_pkg::led_t   leds_o,
    output logic                start_o,
    output logic                check_only_o,
    output logic                lfsr_mode_o,
    output logic                clear_o,
    output memtest_pkg::maddr_t addr_start_o,
    output memtest_pkg::maddr_t addr_stop_o,
    input  logic                busy_i,
    input  logic                pass_i,
    input  logic                fail_i,
    input  memtest_pkg::count_t iterations_i,
    input  memtest_pkg::count_t errors_i,
    input  memtest_pkg::maddr_t err_addr_i,
    mem_port_if.requester       man
);

    logic [3:0]          ctrl_q;        // flash_all, led_test, lfsr_mode, check_only
    memtest_pkg::maddr_t rng_start_q;
    memtest_pkg::maddr_t rng_stop_q;
    memtest_pkg::maddr_t maddr_q;
    memtest_pkg::word_t  mwdata_q;
    memtest_pkg::word_t  mrdata_q;
    memtest_pkg::led_t   leds_q;        // software pattern for led test mode
    logic                rdone_q;
    logic                man_wr_q;
    logic                man_rd_q;
    logic                start_p_q;
    logic                clear_p_q;
    logic [`HB_W-1:0]    hb_q;
    memtest_pkg::word_t  rd_mux;
    memtest_pkg::word_t  rdata_q;
    logic                rvalid_q;
    logic                wr_ctrl;
    logic                wr_mread;
    logic                hb;

    assign wr_ctrl  = reg_write_i && (reg_addr_i == `R_CTRL);
    assign wr_mread = reg_write_i && (reg_addr_i == `R_MREAD);
    assign hb       = hb_q[`HB_W-1];

    always_ff @(posedge mainclk_buf or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q      <= '0;
            rng_start_q <= '0;
            rng_stop_q  <= '0;
            maddr_q     <= '0;
            mwdata_q    <= '0;
            mrdata_q    <= '0;
            leds_q      <= '0;
            rdone_q     <= 1'b0;
            man_wr_q    <= 1'b0;
            man_rd_q    <= 1'b0;
            start_p_q   <= 1'b0;
            clear_p_q   <= 1'b0;
            hb_q        <= '0;
            rdata_q     <= '0;
            rvalid_q    <= 1'b0;
        end else begin
            hb_q      <= hb_q + 1'b1;
            start_p_q <= wr_ctrl && reg_wdata_i[31];    // command bits, not stored
            clear_p_q <= wr_ctrl && reg_wdata_i[30];
            man_wr_q  <= reg_write_i && (reg_addr_i == `R_MWDATA);
            man_rd_q  <= wr_mread;
            rvalid_q  <= reg_read_i;
            if (reg_read_i)
                rdata_q <= rd_mux;
            if (reg_write_i) begin
                case (reg_addr_i)
                    `R_CTRL:   ctrl_q      <= reg_wdata_i[3:0];
                    `R_START:  rng_start_q <= reg_wdata_i[`MEM_AW-1:0];
                    `R_STOP:   rng_stop_q  <= reg_wdata_i[`MEM_AW-1:0];
                    `R_MADDR:  maddr_q     <= reg_wdata_i[`MEM_AW-1:0];
                    `R_MWDATA: mwdata_q    <= reg_wdata_i;
                    `R_LEDS:   leds_q      <= reg_wdata_i[7:0];
                    default: ;
                endcase
            end
            // manual read return lands RD_LAT after the rd strobe
            if (man.rvalid) begin
                mrdata_q <= man.rdata;
                rdone_q  <= 1'b1;
            end else if (wr_mread) begin
                rdone_q  <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_mux = '0;
        case (reg_addr_i)
            `R_CTRL:    rd_mux[3:0]         = ctrl_q;
            `R_START:   rd_mux[`MEM_AW-1:0] = rng_start_q;
            `R_STOP:    rd_mux[`MEM_AW-1:0] = rng_stop_q;
            `R_STATUS:  rd_mux[3:0]         = {rdone_q, fail_i, pass_i, busy_i};
            `R_ITER:    rd_mux[15:0]        = iterations_i;
            `R_ERRS:    rd_mux[15:0]        = errors_i;
            `R_ERRADDR: rd_mux[`MEM_AW-1:0] = err_addr_i;
            `R_MADDR:   rd_mux[`MEM_AW-1:0] = maddr_q;
            `R_MWDATA:  rd_mux              = mwdata_q;
            `R_MRDATA:  rd_mux              = mrdata_q;
            `R_LEDS:    rd_mux[7:0]         = leds_q;
            default:    rd_mux              = '0;
        endcase
    end

    always_comb begin
        if (ctrl_q[2] && ctrl_q[3])
            leds_o = {8{hb}};                               // flash all
        else if (ctrl_q[2])
            leds_o = leds_q;
        else
            leds_o = {4'b0000, fail_i, pass_i, busy_i, hb};
    end

    assign reg_rdata_o  = rdata_q;
    assign reg_rvalid_o = rvalid_q;
    assign start_o      = start_p_q;
    assign clear_o      = clear_p_q;
    assign check_only_o = ctrl_q[0];
    assign lfsr_mode_o  = ctrl_q[1];
    assign addr_start_o = rng_start_q;
    assign addr_stop_o  = rng_stop_q;

    assign man.wr    = man_wr_q;
    assign man.rd    = man_rd_q;
    assign man.addr  = maddr_q;
    assign man.wdata = mwdata_q;

endmodule

/* memtest_top.sv */
// memory self-test top level
// host register port and LEDs to control, test engine, arbiter and ram
`timescale 1ns/1ps

module memtest_top (
    input  logic                mainclk_buf,
    input  logic                rst_n_i,
    input  memtest_pkg::raddr_t reg_addr_i,
    input  memtest_pkg::word_t  reg_wdata_i,
    input  logic                reg_write_i,
    input  logic                reg_read_i,
    output memtest_pkg::word_t  reg_rdata_o,
    output logic                reg_rvalid_o,
    output memtest_pkg::led_t   leds_o
);

    mem_port_if man_port ();
    mem_port_if tst_port ();
    mem_port_if ram_port ();

    logic                tst_start;
    logic                tst_check_only;
    logic                tst_lfsr_mode;
    logic                tst_clear;
    memtest_pkg::maddr_t tst_addr_start;
    memtest_pkg::maddr_t tst_addr_stop;
    logic                tst_busy;
    logic                tst_pass;
    logic                tst_fail;
    memtest_pkg::count_t tst_iterations;
    memtest_pkg::count_t tst_errors;
    memtest_pkg::maddr_t tst_err_addr;

    ctrl_regs u_ctrl_regs (
        .mainclk_buf  (mainclk_buf),
        .rst_n_i      (rst_n_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_write_i  (reg_write_i),
        .reg_read_i   (reg_read_i),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rvalid_o (reg_rvalid_o),
        .leds_o       (leds_o),
        .start_o      (tst_start),
        .check_only_o (tst_check_only),
        .lfsr_mode_o  (tst_lfsr_mode),
        .clear_o      (tst_clear),
        .addr_start_o (tst_addr_start),
        .addr_stop_o  (tst_addr_stop),
        .busy_i       (tst_busy),
        .pass_i       (tst_pass),
        .fail_i       (tst_fail),
        .iterations_i (tst_iterations),
        .errors_i     (tst_errors),
        .err_addr_i   (tst_err_addr),
        .man          (man_port)
    );

    mem_tester u_mem_tester (
        .mainclk_buf  (mainclk_buf),
        .rst_n_i      (rst_n_i),
        .start_i      (tst_start),
        .check_only_i (tst_check_only),
        .lfsr_mode_i  (tst_lfsr_mode),
        .clear_i      (tst_clear),
        .addr_start_i (tst_addr_start),
        .addr_stop_i  (tst_addr_stop),
        .busy_o       (tst_busy),
        .pass_o       (tst_pass),
        .fail_o       (tst_fail),
        .iterations_o (tst_iterations),
        .errors_o     (tst_errors),
        .err_addr_o   (tst_err_addr),
        .mem          (tst_port)
    );

    mem_arbiter u_mem_arbiter (
        .mainclk_buf (mainclk_buf),
        .rst_n_i     (rst_n_i),
        .man         (man_port),
        .tst         (tst_port),
        .ram         (ram_port)
    );

    test_ram u_test_ram (
        .mainclk_buf (mainclk_buf),
        .rst_n_i     (rst_n_i),
        .mem         (ram_port)
    );

endmodule

/* memtest_tb.sv */
// testbench for the memory self-test top level
// host bus tasks, directed tests with random data, checking assertions
`timescale 1ns/1ps
`include "memtest_config.svh"

module memtest_tb;

    logic                mainclk_buf;
    logic                rst_n_i;
    memtest_pkg::raddr_t reg_addr_i;
    memtest_pkg::word_t  reg_wdata_i;
    logic                reg_write_i;
    logic                reg_read_i;
    memtest_pkg::word_t  reg_rdata_o;
    logic                reg_rvalid_o;
    memtest_pkg::led_t   leds_o;

    int                  errors;
    int                  checks;
    int                  tests;
    memtest_pkg::word_t  model [0:(1 << `MEM_AW)-1];   // expected memory contents
    logic [3:0]          ctrl_sh;       // CTRL bits as last written
    memtest_pkg::led_t   leds_sh;
    logic [3:0]          mread_sr;      // age of the last manual read request
    logic                read_q;

    memtest_top UUT (
        .mainclk_buf  (mainclk_buf),
        .rst_n_i      (rst_n_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_write_i  (reg_write_i),
        .reg_read_i   (reg_read_i),
        .reg_rdata_o  (reg_rdata_o),
        .reg_rvalid_o (reg_rvalid_o),
        .leds_o       (leds_o)
    );

    always #10 mainclk_buf = ~mainclk_buf;

    always_ff @(posedge mainclk_buf or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mread_sr <= '0;
            read_q   <= 1'b0;
        end else begin
            mread_sr <= {mread_sr[2:0], reg_write_i && (reg_addr_i == `R_MREAD)};
            read_q   <= reg_read_i;
        end
    end

    a_rvalid_follows: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        reg_rvalid_o == read_q)
    else begin
        $display("Error: reg_rvalid_o expected %h got %h", $sampled(read_q),
                 $sampled(reg_rvalid_o));
        errors++;
    end

    // rdone lands on the third edge after the one that takes the request
    a_rdone_set: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        mread_sr[3] |-> UUT.u_ctrl_regs.rdone_q)
    else begin
        $display("STATUS.rdone was not set 3 cycles after the manual read request");
        errors++;
    end

    a_rdone_early: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        (|mread_sr[2:0]) |-> !UUT.u_ctrl_regs.rdone_q)
    else begin
        $display("STATUS.rdone was set too early or not cleared by a new manual read");
        errors++;
    end

    a_led_status: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        !ctrl_sh[2] |-> leds_o[7:1] == {4'b0000, UUT.tst_fail, UUT.tst_pass, UUT.tst_busy})
    else begin
        $display("Error: leds_o[7:1] expected %h got %h",
                 $sampled({4'b0000, UUT.tst_fail, UUT.tst_pass, UUT.tst_busy}),
                 $sampled(leds_o[7:1]));
        errors++;
    end

    a_led_pattern: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        (ctrl_sh[2] && !ctrl_sh[3]) |-> leds_o == leds_sh)
    else begin
        $display("Error: leds_o expected %h got %h", $sampled(leds_sh), $sampled(leds_o));
        errors++;
    end

    a_led_flash: assert property (@(posedge mainclk_buf) disable iff (!rst_n_i)
        (ctrl_sh[2] && ctrl_sh[3]) |-> (leds_o == 8'h00 || leds_o == 8'hFF))
    else begin
        $display("Error: leds_o expected all bits equal, got %h", $sampled(leds_o));
        errors++;
    end

    function automatic memtest_pkg::word_t next_lfsr(input memtest_pkg::word_t v);
        next_lfsr = {1'b0, v[31:1]} ^ ({32{v[0]}} & `LFSR_TAPS);  // galois shift right
    endfunction

    task automatic reg_wr(input memtest_pkg::raddr_t a, input memtest_pkg::word_t d);
        @(posedge mainclk_buf);
        #1;
        reg_addr_i  = a;
        reg_wdata_i = d;
        reg_write_i = 1'b1;
        @(posedge mainclk_buf);
        #1;
        reg_write_i = 1'b0;
        if (a == `R_CTRL)
            ctrl_sh = d[3:0];
        if (a == `R_LEDS)
            leds_sh = d[7:0];
    endtask

    task automatic reg_rd(input memtest_pkg::raddr_t a, output memtest_pkg::word_t d);
        int n;
        @(posedge mainclk_buf);
        #1;
        reg_addr_i = a;
        reg_read_i = 1'b1;
        @(posedge mainclk_buf);
        #1;
        reg_read_i = 1'b0;
        n = 0;
        while (!reg_rvalid_o && n < 8) begin
            @(posedge mainclk_buf);
            #1;
            n++;
        end
        if (!reg_rvalid_o) begin
            $display("no read response for register %h", a);
            errors++;
        end
        d = reg_rdata_o;
    endtask

    task automatic check_value(input string name, input memtest_pkg::word_t got,
                               input memtest_pkg::word_t exp);
        checks++;
        assert (got === exp)
        else begin
            $display("Error: %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_reg(input memtest_pkg::raddr_t a, input string name,
                             input memtest_pkg::word_t exp, input memtest_pkg::word_t mask);
        memtest_pkg::word_t v;
        reg_rd(a, v);
        check_value(name, v & mask, exp);
    endtask

    task automatic man_write(input memtest_pkg::maddr_t a, input memtest_pkg::word_t d);
        reg_wr(`R_MADDR, memtest_pkg::word_t'(a));
        reg_wr(`R_MWDATA, d);
        model[a] = d;
    endtask

    task automatic man_read(input memtest_pkg::maddr_t a, output memtest_pkg::word_t d);
        memtest_pkg::word_t st;
        int n;
        reg_wr(`R_MADDR, memtest_pkg::word_t'(a));
        reg_wr(`R_MREAD, '0);
        n = 0;
        reg_rd(`R_STATUS, st);
        while (!st[3] && n < 10) begin
            reg_rd(`R_STATUS, st);
            n++;
        end
        if (!st[3]) begin
            $display("manual read of address %h never completed", a);
            errors++;
        end
        reg_rd(`R_MRDATA, d);
    endtask

    // start pulse and mode bits go in one CTRL write
    task automatic run_engine(input memtest_pkg::word_t ctrl);
        memtest_pkg::word_t st;
        int n;
        reg_wr(`R_CTRL, ctrl);
        n = 0;
        reg_rd(`R_STATUS, st);
        while (st[0] && n < 400) begin
            reg_rd(`R_STATUS, st);
            n++;
        end
        if (st[0]) begin
            $display("test engine still busy after %0d status polls", n);
            errors++;
        end
    endtask

    task automatic set_range(input memtest_pkg::maddr_t lo, input memtest_pkg::maddr_t hi);
        reg_wr(`R_START, memtest_pkg::word_t'(lo));
        reg_wr(`R_STOP, memtest_pkg::word_t'(hi));
    endtask

    task automatic end_test(input string name, input int e0);
        tests++;
        if (errors == e0)
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d failed checks", tests, name, errors - e0);
    endtask

    initial begin
        memtest_pkg::word_t  v;
        memtest_pkg::word_t  pat;
        memtest_pkg::maddr_t a;
        memtest_pkg::maddr_t lo;
        memtest_pkg::maddr_t hi;
        memtest_pkg::maddr_t bad [3];
        memtest_pkg::maddr_t addrs [$];
        int                  e0;
        int                  len;
        void'($urandom(32'hd894_5a85));
        errors      = 0;
        checks      = 0;
        tests       = 0;
        ctrl_sh     = '0;
        leds_sh     = '0;
        mainclk_buf = 1'b0;
        rst_n_i     = 1'b0;
        reg_addr_i  = '0;
        reg_wdata_i = '0;
        reg_write_i = 1'b0;
        reg_read_i  = 1'b0;
        repeat (16) @(posedge mainclk_buf);
        #1;
        rst_n_i = 1'b1;

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = memtest_pkg::maddr_t'($urandom);
            man_write(a, $urandom);
            addrs.push_back(a);
        end
        foreach (addrs[i]) begin
            man_read(addrs[i], v);
            check_value("R_MRDATA", v, model[addrs[i]]);
        end
        end_test("manual access", e0);

        e0 = errors;
        lo = memtest_pkg::maddr_t'($urandom_range(0, 150));
        hi = lo + memtest_pkg::maddr_t'($urandom_range(8, 60));
        set_range(lo, hi);
        run_engine(32'h8000_0000);              // address pattern, write and compare
        check_reg(`R_STATUS, "STATUS[2:0]", 32'h2, 32'h7);
        check_reg(`R_ITER, "ITER", 32'd1, '1);
        check_reg(`R_ERRS, "ERRS", 32'd0, '1);
        for (int k = lo; k <= hi; k++) begin
            man_read(memtest_pkg::maddr_t'(k), v);
            check_value("R_MRDATA", v, memtest_pkg::word_t'(k));
        end
        end_test("address pattern", e0);

        e0 = errors;
        reg_wr(`R_CTRL, 32'h4000_0000);
        lo  = memtest_pkg::maddr_t'($urandom_range(0, 100));
        len = $urandom_range(25, 61);
        hi  = lo + memtest_pkg::maddr_t'(len - 1);
        set_range(lo, hi);
        run_engine(32'h8000_0002);
        pat = `LFSR_SEED;
        for (int k = lo; k <= hi; k++) begin
            model[k] = pat;
            pat      = next_lfsr(pat);
        end
        man_read(lo, v);
        check_value("R_MRDATA", v, model[lo]);
        man_read(hi, v);
        check_value("R_MRDATA", v, model[hi]);
        run_engine(32'h8000_0003);              // compare only
        check_reg(`R_STATUS, "STATUS[2:0]", 32'h2, 32'h7);
        check_reg(`R_ITER, "ITER", 32'd2, '1);
        for (int j = 0; j < 3; j++) begin
            bad[j] = lo + memtest_pkg::maddr_t'(j * (len / 3) + $urandom_range(0, len / 3 - 1));
            man_write(bad[j], model[bad[j]] ^ ($urandom | 32'h1));
        end
        run_engine(32'h8000_0003);
        check_reg(`R_STATUS, "STATUS[2:0]", 32'h4, 32'h7);
        check_reg(`R_ERRS, "ERRS", 32'd3, '1);
        check_reg(`R_ERRADDR, "ERRADDR", memtest_pkg::word_t'(bad[0]), '1);
        end_test("lfsr pattern", e0);

        e0 = errors;
        reg_wr(`R_CTRL, 32'h4000_0000);
        check_reg(`R_ITER, "ITER", 32'd0, '1);
        check_reg(`R_ERRS, "ERRS", 32'd0, '1);
        check_reg(`R_STATUS, "STATUS[2:1]", 32'h0, 32'h6);
        end_test("clear", e0);

        // manual writes above the range while the engine runs
        e0 = errors;
        lo = memtest_pkg::maddr_t'($urandom_range(8'h40, 8'h60));
        hi = lo + 8'd63;
        set_range(lo, hi);
        addrs.delete();
        reg_wr(`R_CTRL, 32'h8000_0000);
        for (int j = 0; j < 6; j++) begin
            repeat ($urandom_range(0, 5)) @(posedge mainclk_buf);
            a = 8'hC0 + memtest_pkg::maddr_t'(j * 8 + $urandom_range(0, 7));
            man_write(a, $urandom);
            addrs.push_back(a);
        end
        run_engine(32'h0);                      // no start, just wait for idle
        check_reg(`R_STATUS, "STATUS[2:0]", 32'h2, 32'h7);
        check_reg(`R_ERRS, "ERRS", 32'd0, '1);
        foreach (addrs[i]) begin
            man_read(addrs[i], v);
            check_value("R_MRDATA", v, model[addrs[i]]);
        end
        end_test("manual traffic during test", e0);

        e0 = errors;
        v = $urandom;
        reg_wr(`R_LEDS, v);
        reg_wr(`R_CTRL, 32'h4);
        check_value("leds_o", memtest_pkg::word_t'(leds_o), memtest_pkg::word_t'(v[7:0]));
        reg_wr(`R_CTRL, 32'hC);
        run_engine(32'h8000_0000);              // normal mode, status on the LEDs
        check_value("leds_o[7:1]", memtest_pkg::word_t'(leds_o & 8'hFE), 32'h4);
        end_test("leds", e0);

        $display("tests %0d, checks %0d, failures %0d", tests, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* memtest.f */
+incdir+.
memtest_pkg.sv
mem_port_if.sv
test_ram.sv
mem_arbiter.sv
mem_tester.sv
ctrl_regs.sv
memtest_top.sv
memtest_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the memory self-test testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module memtest_tb -f memtest.f -o memtest_sim

./obj_dir/memtest_sim | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi

echo "simulation passed"
